// File: design/mipsPkg.sv
package mipsPkg;

    //////////////////////////////
    // Widths and depths
    //////////////////////////////
    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int IMEM_DEPTH     = 64;
    localparam int DMEM_DEPTH     = 64;
    localparam int MEM_ADDR_WIDTH = 6;

    //////////////////////////////
    // Opcodes
    //////////////////////////////
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_SW    = 6'b101011;
    localparam logic [5:0] OP_BEQ   = 6'b000100;

    // R-type function field
    localparam logic [5:0] FUNCT_ADD = 6'b100000;
    localparam logic [5:0] FUNCT_SUB = 6'b100010;
    localparam logic [5:0] FUNCT_AND = 6'b100100;
    localparam logic [5:0] FUNCT_OR  = 6'b100101;
    localparam logic [5:0] FUNCT_SLT = 6'b101010;

    //////////////////////////////
    // ALU operation classes
    //////////////////////////////
    // Address arithmetic for LW and SW
    localparam logic [1:0] ALUOP_ADD   = 2'b00;
    // Compare for BEQ
    localparam logic [1:0] ALUOP_SUB   = 2'b01;
    localparam logic [1:0] ALUOP_FUNCT = 2'b10;
    localparam logic [1:0] ALUOP_NONE  = 2'b11;

endpackage

// File: design/mainControl.sv
`timescale 1ns/1ns

module mainControl
(
    input  logic [5:0] i_opcode,

    output logic       o_regDst,
    output logic       o_branch,
    output logic       o_memRead,
    output logic       o_memToReg,
    output logic [1:0] o_aluOp,
    output logic       o_memWrite,
    output logic       o_aluSrc,
    output logic       o_regWrite
);

    always_comb
    begin
        // Unknown opcodes fall out as a no-op
        o_regDst   = 1'b0;
        o_branch   = 1'b0;
        o_memRead  = 1'b0;
        o_memToReg = 1'b0;
        o_aluOp    = mipsPkg::ALUOP_NONE;
        o_memWrite = 1'b0;
        o_aluSrc   = 1'b0;
        o_regWrite = 1'b0;

        case (i_opcode)
            mipsPkg::OP_RTYPE:
            begin
                o_regDst   = 1'b1;
                o_aluOp    = mipsPkg::ALUOP_FUNCT;
                o_regWrite = 1'b1;
            end

            mipsPkg::OP_LW:
            begin
                o_memRead  = 1'b1;
                o_memToReg = 1'b1;
                o_aluOp    = mipsPkg::ALUOP_ADD;
                o_aluSrc   = 1'b1;
                o_regWrite = 1'b1;
            end

            mipsPkg::OP_SW:
            begin
                o_aluOp    = mipsPkg::ALUOP_ADD;
                o_memWrite = 1'b1;
                o_aluSrc   = 1'b1;
            end

            // Subtract so that equal operands raise zero
            mipsPkg::OP_BEQ:
            begin
                o_branch   = 1'b1;
                o_aluOp    = mipsPkg::ALUOP_SUB;
            end

            default:
            begin
                o_aluOp    = mipsPkg::ALUOP_NONE;
            end
        endcase
    end

endmodule

// File: design/aluUnit.sv
`timescale 1ns/1ns

module aluUnit
(
    input  logic [1:0]                     i_aluOp,
    input  logic                           i_aluSrc,
    input  logic [5:0]                     i_funct,
    input  logic [15:0]                    i_immediate,
    input  logic [mipsPkg::DATA_WIDTH-1:0] i_operandA,
    input  logic [mipsPkg::DATA_WIDTH-1:0] i_operandB,

    output logic [mipsPkg::DATA_WIDTH-1:0] o_result,
    output logic                           o_zero
);

    logic [mipsPkg::DATA_WIDTH-1:0] extImmediate;
    logic [mipsPkg::DATA_WIDTH-1:0] operandB;

    // Offset for LW and SW is signed
    assign extImmediate = {{(mipsPkg::DATA_WIDTH - 16){i_immediate[15]}}, i_immediate};
    assign operandB     = i_aluSrc ? extImmediate : i_operandB;

    always_comb
    begin
        o_result = '0;
        case (i_aluOp)
            mipsPkg::ALUOP_ADD:
            begin
                o_result = i_operandA + operandB;
            end

            mipsPkg::ALUOP_SUB:
            begin
                o_result = i_operandA - operandB;
            end

            mipsPkg::ALUOP_FUNCT:
            begin
                case (i_funct)
                    mipsPkg::FUNCT_ADD: o_result = i_operandA + operandB;
                    mipsPkg::FUNCT_SUB: o_result = i_operandA - operandB;
                    mipsPkg::FUNCT_AND: o_result = i_operandA & operandB;
                    mipsPkg::FUNCT_OR:  o_result = i_operandA | operandB;
                    // Two's complement compare
                    mipsPkg::FUNCT_SLT:
                        o_result = {{(mipsPkg::DATA_WIDTH - 1){1'b0}},
                                    $signed(i_operandA) < $signed(operandB)};
                    default:            o_result = '0;
                endcase
            end

            default:
            begin
                o_result = '0;
            end
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

// File: design/registerFile.sv
`timescale 1ns/1ns

module registerFile
(
    input  logic                               i_clock,
    input  logic                               i_reset,
    input  logic [mipsPkg::REG_ADDR_WIDTH-1:0] i_readAddrA,
    input  logic [mipsPkg::REG_ADDR_WIDTH-1:0] i_readAddrB,
    input  logic [mipsPkg::REG_ADDR_WIDTH-1:0] i_rtAddr,
    input  logic [mipsPkg::REG_ADDR_WIDTH-1:0] i_rdAddr,
    input  logic                               i_regDst,
    input  logic                               i_regWrite,
    input  logic                               i_memRead,
    input  logic                               i_memToReg,
    input  logic [mipsPkg::DATA_WIDTH-1:0]     i_aluResult,
    input  logic [mipsPkg::DATA_WIDTH-1:0]     i_memData,

    output logic [mipsPkg::DATA_WIDTH-1:0]     o_readDataA,
    output logic [mipsPkg::DATA_WIDTH-1:0]     o_readDataB,
    output logic                               o_writeEnable,
    output logic [mipsPkg::REG_ADDR_WIDTH-1:0] o_writeAddr,
    output logic [mipsPkg::DATA_WIDTH-1:0]     o_writeData
);

    localparam int NUM_REGS = 2 ** mipsPkg::REG_ADDR_WIDTH;

    logic [mipsPkg::DATA_WIDTH-1:0] regs [NUM_REGS];

    //////////////////////////////
    // Writeback selection
    //////////////////////////////
    // R-type writes rd, LW writes rt
    assign o_writeAddr   = i_regDst ? i_rdAddr : i_rtAddr;
    assign o_writeData   = (i_memToReg && i_memRead) ? i_memData : i_aluResult;
    // $zero never takes a write
    assign o_writeEnable = i_regWrite && !i_reset && (o_writeAddr != '0);

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (o_writeEnable)
        begin
            regs[o_writeAddr] <= o_writeData;
        end
    end

    // Reads are combinational
    assign o_readDataA = (i_readAddrA == '0) ? '0 : regs[i_readAddrA];
    assign o_readDataB = (i_readAddrB == '0) ? '0 : regs[i_readAddrB];

endmodule

// File: design/fetchUnit.sv
`timescale 1ns/1ns

module fetchUnit
(
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  logic                           i_branch,
    input  logic                           i_zero,
    input  logic [15:0]                    i_immediate,

    output logic [mipsPkg::DATA_WIDTH-1:0] o_pc
);

    logic [mipsPkg::DATA_WIDTH-1:0] pcPlus4;
    logic [mipsPkg::DATA_WIDTH-1:0] branchOffset;
    logic [mipsPkg::DATA_WIDTH-1:0] nextPc;

    assign pcPlus4      = o_pc + 32'd4;
    // Word offset turned into bytes
    assign branchOffset = {{(mipsPkg::DATA_WIDTH - 18){i_immediate[15]}}, i_immediate, 2'b00};
    assign nextPc       = (i_branch && i_zero) ? pcPlus4 + branchOffset : pcPlus4;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_pc <= '0;
        end
        else
        begin
            o_pc <= nextPc;
        end
    end

endmodule

// File: design/instructionMemory.sv
`timescale 1ns/1ns

module instructionMemory
(
    input  logic                               i_clock,
    input  logic                               i_loadWrite,
    input  logic [mipsPkg::MEM_ADDR_WIDTH-1:0] i_loadAddress,
    input  logic [mipsPkg::DATA_WIDTH-1:0]     i_loadData,
    input  logic [mipsPkg::DATA_WIDTH-1:0]     i_pc,

    output logic [mipsPkg::DATA_WIDTH-1:0]     o_instruction
);

    logic [mipsPkg::DATA_WIDTH-1:0] mem [mipsPkg::IMEM_DEPTH];

    // Program is written only through the load port
    always_ff @(posedge i_clock)
    begin
        if (i_loadWrite)
        begin
            mem[i_loadAddress] <= i_loadData;
        end
    end

    assign o_instruction = mem[i_pc[mipsPkg::MEM_ADDR_WIDTH+1:2]];

endmodule

// File: design/dataMemory.sv
`timescale 1ns/1ns

module dataMemory
(
    input  logic                               i_clock,
    input  logic                               i_reset,
    input  logic                               i_loadWrite,
    input  logic [mipsPkg::MEM_ADDR_WIDTH-1:0] i_loadAddress,
    input  logic [mipsPkg::DATA_WIDTH-1:0]     i_loadData,
    input  logic                               i_memWrite,
    input  logic [mipsPkg::DATA_WIDTH-1:0]     i_address,
    input  logic [mipsPkg::DATA_WIDTH-1:0]     i_writeData,

    output logic [mipsPkg::DATA_WIDTH-1:0]     o_readData,
    output logic                               o_writeEnable
);

    logic [mipsPkg::DATA_WIDTH-1:0]     mem [mipsPkg::DMEM_DEPTH];
    logic [mipsPkg::MEM_ADDR_WIDTH-1:0] wordIndex;

    // Byte address down to a word index
    assign wordIndex     = i_address[mipsPkg::MEM_ADDR_WIDTH+1:2];
    assign o_writeEnable = i_memWrite && !i_reset;

    always_ff @(posedge i_clock)
    begin
        if (i_loadWrite)
        begin
            mem[i_loadAddress] <= i_loadData;
        end
        else if (o_writeEnable)
        begin
            mem[wordIndex] <= i_writeData;
        end
    end

    assign o_readData = mem[wordIndex];

endmodule

// File: design/mipsCore.sv
`timescale 1ns/1ns

module mipsCore
(
    input  logic                               i_clock,
    input  logic                               i_reset,
    input  logic                               i_instrLoad,
    input  logic                               i_dataLoad,
    input  logic [mipsPkg::MEM_ADDR_WIDTH-1:0] i_loadAddress,
    input  logic [mipsPkg::DATA_WIDTH-1:0]     i_loadData,

    output logic [mipsPkg::DATA_WIDTH-1:0]     o_pc,
    output logic                               o_regWrite,
    output logic [mipsPkg::REG_ADDR_WIDTH-1:0] o_writeRegister,
    output logic [mipsPkg::DATA_WIDTH-1:0]     o_writeData,
    output logic                               o_memWrite,
    output logic [mipsPkg::DATA_WIDTH-1:0]     o_memAddress,
    output logic [mipsPkg::DATA_WIDTH-1:0]     o_memWriteData
);

    //////////////////////////////
    // Instruction fields
    //////////////////////////////
    logic [mipsPkg::DATA_WIDTH-1:0]     instruction;
    logic [5:0]                         opcode;
    logic [mipsPkg::REG_ADDR_WIDTH-1:0] rs;
    logic [mipsPkg::REG_ADDR_WIDTH-1:0] rt;
    logic [mipsPkg::REG_ADDR_WIDTH-1:0] rd;
    logic [5:0]                         funct;
    logic [15:0]                        immediate;

    assign opcode    = instruction[31:26];
    assign rs        = instruction[25:21];
    assign rt        = instruction[20:16];
    assign rd        = instruction[15:11];
    assign funct     = instruction[5:0];
    assign immediate = instruction[15:0];

    // Control levels
    logic       regDst;
    logic       branch;
    logic       memRead;
    logic       memToReg;
    logic [1:0] aluOp;
    logic       memWrite;
    logic       aluSrc;
    logic       regWrite;

    // Datapath
    logic [mipsPkg::DATA_WIDTH-1:0] readDataA;
    logic [mipsPkg::DATA_WIDTH-1:0] readDataB;
    logic [mipsPkg::DATA_WIDTH-1:0] aluResult;
    logic                           aluZero;
    logic [mipsPkg::DATA_WIDTH-1:0] memReadData;

    //////////////////////////////
    // Blocks
    //////////////////////////////
    fetchUnit u_fetchUnit (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_branch    (branch),
        .i_zero      (aluZero),
        .i_immediate (immediate),
        .o_pc        (o_pc)
    );

    instructionMemory u_instructionMemory (
        .i_clock       (i_clock),
        .i_loadWrite   (i_instrLoad),
        .i_loadAddress (i_loadAddress),
        .i_loadData    (i_loadData),
        .i_pc          (o_pc),
        .o_instruction (instruction)
    );

    mainControl u_mainControl (
        .i_opcode   (opcode),
        .o_regDst   (regDst),
        .o_branch   (branch),
        .o_memRead  (memRead),
        .o_memToReg (memToReg),
        .o_aluOp    (aluOp),
        .o_memWrite (memWrite),
        .o_aluSrc   (aluSrc),
        .o_regWrite (regWrite)
    );

    registerFile u_registerFile (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_readAddrA   (rs),
        .i_readAddrB   (rt),
        .i_rtAddr      (rt),
        .i_rdAddr      (rd),
        .i_regDst      (regDst),
        .i_regWrite    (regWrite),
        .i_memRead     (memRead),
        .i_memToReg    (memToReg),
        .i_aluResult   (aluResult),
        .i_memData     (memReadData),
        .o_readDataA   (readDataA),
        .o_readDataB   (readDataB),
        .o_writeEnable (o_regWrite),
        .o_writeAddr   (o_writeRegister),
        .o_writeData   (o_writeData)
    );

    aluUnit u_aluUnit (
        .i_aluOp     (aluOp),
        .i_aluSrc    (aluSrc),
        .i_funct     (funct),
        .i_immediate (immediate),
        .i_operandA  (readDataA),
        .i_operandB  (readDataB),
        .o_result    (aluResult),
        .o_zero      (aluZero)
    );

    dataMemory u_dataMemory (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_loadWrite   (i_dataLoad),
        .i_loadAddress (i_loadAddress),
        .i_loadData    (i_loadData),
        .i_memWrite    (memWrite),
        .i_address     (aluResult),
        .i_writeData   (readDataB),
        .o_readData    (memReadData),
        .o_writeEnable (o_memWrite)
    );

    // Store side of the commit
    assign o_memAddress   = aluResult;
    assign o_memWriteData = readDataB;

endmodule

// File: sim/mipsCore_sva.sv
`timescale 1ns/1ns

module mipsCore_sva
(
    input logic                           i_clock,
    input logic                           i_reset,
    input logic [mipsPkg::DATA_WIDTH-1:0] i_pc,
    input logic                           i_regWrite,
    input logic                           i_memWrite,
    input logic                           i_branch,
    input logic                           i_zero
);

    // Count of failed properties
    int failCount = 0;

    // A commit goes to registers or to memory, never both
    assert property (@(posedge i_clock) !(i_regWrite && i_memWrite))
        else
        begin
            $error("register and memory write enables high in the same cycle");
            failCount++;
        end

    // Sequential flow
    assert property (@(posedge i_clock) disable iff (i_reset)
        !(i_branch && i_zero) |=> (i_pc == $past(i_pc) + 32'd4))
        else
        begin
            $error("pc did not advance by 4 without a taken branch");
            failCount++;
        end

    assert property (@(posedge i_clock) i_reset |-> (!i_regWrite && !i_memWrite))
        else
        begin
            $error("write enable high during reset");
            failCount++;
        end

endmodule

bind mipsCore mipsCore_sva u_mipsCore_sva (
    .i_clock    (i_clock),
    .i_reset    (i_reset),
    .i_pc       (o_pc),
    .i_regWrite (o_regWrite),
    .i_memWrite (o_memWrite),
    .i_branch   (branch),
    .i_zero     (aluZero)
);

// File: sim/mipsCore_tb.sv
`timescale 1ns/1ns

module mipsCore_tb;

    localparam int RESET_CYCLES = 2;
    localparam int NUM_TESTS    = 6;
    // Instructions executed over all tests
    localparam int INSTR_CYCLES = 48;
    // Reset, program load and full data load per test
    localparam int SETUP_CYCLES = NUM_TESTS * (RESET_CYCLES + 16 + mipsPkg::DMEM_DEPTH);
    localparam int TIMEOUT_NS   = 2 * (INSTR_CYCLES + SETUP_CYCLES + RESET_CYCLES) * 10;

    logic                               clock;
    logic                               reset;
    logic                               instrLoad;
    logic                               dataLoad;
    logic [mipsPkg::MEM_ADDR_WIDTH-1:0] loadAddress;
    logic [31:0]                        loadData;
    logic [31:0]                        pc;
    logic                               regWrite;
    logic [4:0]                         writeRegister;
    logic [31:0]                        writeData;
    logic                               memWrite;
    logic [31:0]                        memAddress;
    logic [31:0]                        memWriteData;

    //////////////////////////////
    // Reference model state
    //////////////////////////////
    logic [31:0] modelReg [32];
    logic [31:0] modelMem [mipsPkg::DMEM_DEPTH];
    logic [31:0] modelPc;
    logic [31:0] progWords [$];
    logic [31:0] pcTrace [$];

    // Expected commit of the current instruction
    logic        expRegWrite;
    logic [4:0]  expWriteReg;
    logic [31:0] expWriteData;
    logic        expMemWrite;
    logic [31:0] expMemAddr;
    logic [31:0] expMemData;
    logic [31:0] expNextPc;

    int errorCount;
    int testErrors;
    int testsRun;
    int testsFailed;

    mipsCore u_mipsCore (
        .i_clock         (clock),
        .i_reset         (reset),
        .i_instrLoad     (instrLoad),
        .i_dataLoad      (dataLoad),
        .i_loadAddress   (loadAddress),
        .i_loadData      (loadData),
        .o_pc            (pc),
        .o_regWrite      (regWrite),
        .o_writeRegister (writeRegister),
        .o_writeData     (writeData),
        .o_memWrite      (memWrite),
        .o_memAddress    (memAddress),
        .o_memWriteData  (memWriteData)
    );

    initial
    begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Watchdog
    initial
    begin
        #(TIMEOUT_NS);
        $display("simulation timed out after %0d ns", TIMEOUT_NS);
        $display("test failed");
        $finish;
    end

    //////////////////////////////
    // Encoders and helpers
    //////////////////////////////
    function automatic logic [31:0] rType(input int rs, input int rt, input int rd,
                                          input logic [5:0] funct);
        return {mipsPkg::OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input int rs, input int rt,
                                          input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic waitCycle();
        @(posedge clock);
        #1;
    endtask

    task automatic reportMismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        errorCount++;
        testErrors++;
    endtask

    task automatic resetCore(input int cycles);
        reset = 1'b1;
        repeat (cycles)
        begin
            #8;
            assert (!regWrite && !memWrite)
                else reportMismatch("write enable high during reset");
            waitCycle();
            assert (pc === 32'd0)
                else reportMismatch($sformatf("o_pc %h in reset, expected 0", pc));
        end
    endtask

    // Both memories are written while reset is held
    task automatic loadMemories();
        for (int i = 0; i < progWords.size(); i++)
        begin
            instrLoad   = 1'b1;
            loadAddress = i[mipsPkg::MEM_ADDR_WIDTH-1:0];
            loadData    = progWords[i];
            waitCycle();
        end
        instrLoad = 1'b0;
        for (int i = 0; i < mipsPkg::DMEM_DEPTH; i++)
        begin
            dataLoad    = 1'b1;
            loadAddress = i[mipsPkg::MEM_ADDR_WIDTH-1:0];
            loadData    = modelMem[i];
            waitCycle();
        end
        dataLoad = 1'b0;
    endtask

    task automatic releaseReset();
        for (int i = 0; i < 32; i++)
        begin
            modelReg[i] = 32'd0;
        end
        modelPc = 32'd0;
        pcTrace.delete();
        reset   = 1'b0;
    endtask

    task automatic prepare();
        resetCore(RESET_CYCLES);
        loadMemories();
        releaseReset();
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////
    task automatic predict(input logic [31:0] instr);
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ext;
        op  = instr[31:26];
        rs  = instr[25:21];
        rt  = instr[20:16];
        rd  = instr[15:11];
        a   = modelReg[rs];
        b   = modelReg[rt];
        ext = {{16{instr[15]}}, instr[15:0]};
        expRegWrite  = 1'b0;
        expWriteReg  = 5'd0;
        expWriteData = 32'd0;
        expMemWrite  = 1'b0;
        expMemAddr   = 32'd0;
        expMemData   = 32'd0;
        expNextPc    = modelPc + 32'd4;
        case (op)
            mipsPkg::OP_RTYPE:
            begin
                expWriteReg = rd;
                expRegWrite = (rd != 5'd0);
                case (instr[5:0])
                    mipsPkg::FUNCT_ADD: expWriteData = a + b;
                    mipsPkg::FUNCT_SUB: expWriteData = a - b;
                    mipsPkg::FUNCT_AND: expWriteData = a & b;
                    mipsPkg::FUNCT_OR:  expWriteData = a | b;
                    mipsPkg::FUNCT_SLT: expWriteData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:            expWriteData = 32'd0;
                endcase
            end
            mipsPkg::OP_LW:
            begin
                expMemAddr   = a + ext;
                expWriteReg  = rt;
                expWriteData = modelMem[expMemAddr[7:2]];
                expRegWrite  = (rt != 5'd0);
            end
            mipsPkg::OP_SW:
            begin
                expMemAddr  = a + ext;
                expMemData  = b;
                expMemWrite = 1'b1;
            end
            mipsPkg::OP_BEQ:
            begin
                if (a == b)
                begin
                    expNextPc = modelPc + 32'd4 + {ext[29:0], 2'b00};
                end
            end
            default:
            begin
                expNextPc = modelPc + 32'd4;
            end
        endcase
    endtask

    task automatic checkCommit();
        assert (pc === modelPc)
            else reportMismatch($sformatf("o_pc %h, expected %h", pc, modelPc));
        assert (regWrite === expRegWrite)
            else reportMismatch($sformatf("o_regWrite %b at pc %h", regWrite, modelPc));
        if (expRegWrite)
        begin
            assert ({writeRegister, writeData} === {expWriteReg, expWriteData})
                else reportMismatch($sformatf("write r%0d=%h, expected r%0d=%h",
                    writeRegister, writeData, expWriteReg, expWriteData));
        end
        assert (memWrite === expMemWrite)
            else reportMismatch($sformatf("o_memWrite %b at pc %h", memWrite, modelPc));
        if (expMemWrite)
        begin
            assert ({memAddress, memWriteData} === {expMemAddr, expMemData})
                else reportMismatch($sformatf("store [%h]=%h, expected [%h]=%h",
                    memAddress, memWriteData, expMemAddr, expMemData));
        end
    endtask

    // Sample 1 ns before each edge, then commit the model
    task automatic runCycles(input int cycles);
        repeat (cycles)
        begin
            #8;
            predict(progWords[modelPc[7:2]]);
            checkCommit();
            pcTrace.push_back(pc);
            if (expRegWrite)
            begin
                modelReg[expWriteReg] = expWriteData;
            end
            if (expMemWrite)
            begin
                modelMem[expMemAddr[7:2]] = expMemData;
            end
            modelPc = expNextPc;
            waitCycle();
        end
    endtask

    task automatic startTest();
        testErrors = 0;
        progWords.delete();
        for (int i = 0; i < mipsPkg::DMEM_DEPTH; i++)
        begin
            modelMem[i] = $urandom();
        end
    endtask

    task automatic finishTest(input string name);
        $display("[DONE] %s: %0d mismatches", name, testErrors);
        testsRun++;
        if (testErrors > 0)
        begin
            testsFailed++;
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic testLoadStore();
        startTest();
        // Base pointer for the negative offsets
        modelMem[5] = 32'd100;
        progWords.push_back(iType(mipsPkg::OP_LW, 0, 1, 4));
        progWords.push_back(iType(mipsPkg::OP_LW, 0, 2, 8));
        progWords.push_back(iType(mipsPkg::OP_LW, 0, 5, 20));
        progWords.push_back(iType(mipsPkg::OP_SW, 0, 1, 40));
        progWords.push_back(iType(mipsPkg::OP_SW, 0, 2, 44));
        progWords.push_back(iType(mipsPkg::OP_LW, 0, 3, 40));
        progWords.push_back(iType(mipsPkg::OP_LW, 0, 4, 44));
        progWords.push_back(iType(mipsPkg::OP_LW, 5, 6, -8));
        progWords.push_back(iType(mipsPkg::OP_SW, 5, 3, -4));
        prepare();
        runCycles(9);
        finishTest("load and store");
    endtask

    task automatic testArithmetic();
        startTest();
        // Signs forced so SLT differs from an unsigned compare
        modelMem[0][31] = 1'b0;
        modelMem[2][31] = 1'b1;
        progWords.push_back(iType(mipsPkg::OP_LW, 0, 1, 0));
        progWords.push_back(iType(mipsPkg::OP_LW, 0, 2, 4));
        progWords.push_back(iType(mipsPkg::OP_LW, 0, 3, 8));
        progWords.push_back(rType(1, 2, 4, mipsPkg::FUNCT_ADD));
        progWords.push_back(rType(1, 2, 5, mipsPkg::FUNCT_SUB));
        progWords.push_back(rType(1, 2, 6, mipsPkg::FUNCT_AND));
        progWords.push_back(rType(1, 2, 7, mipsPkg::FUNCT_OR));
        progWords.push_back(rType(3, 1, 8, mipsPkg::FUNCT_SLT));
        progWords.push_back(rType(1, 3, 9, mipsPkg::FUNCT_SLT));
        progWords.push_back(rType(1, 1, 10, mipsPkg::FUNCT_SLT));
        prepare();
        runCycles(10);
        finishTest("R-type arithmetic");
    endtask

    task automatic testBranches();
        logic [31:0] path [9] = '{0, 4, 8, 12, 28, 32, 16, 20, 36};
        startTest();
        modelMem[1] = modelMem[0];
        modelMem[2] = ~modelMem[0];
        progWords.push_back(iType(mipsPkg::OP_LW, 0, 1, 0));
        progWords.push_back(iType(mipsPkg::OP_LW, 0, 2, 4));
        progWords.push_back(iType(mipsPkg::OP_LW, 0, 3, 8));
        progWords.push_back(iType(mipsPkg::OP_BEQ, 1, 2, 3));
        progWords.push_back(rType(1, 2, 4, mipsPkg::FUNCT_ADD));
        progWords.push_back(iType(mipsPkg::OP_BEQ, 0, 0, 3));
        progWords.push_back(rType(1, 1, 5, mipsPkg::FUNCT_ADD));
        progWords.push_back(iType(mipsPkg::OP_BEQ, 1, 3, 5));
        progWords.push_back(iType(mipsPkg::OP_BEQ, 2, 2, -5));
        progWords.push_back(rType(1, 3, 6, mipsPkg::FUNCT_SUB));
        prepare();
        runCycles(9);
        // Forward taken, not taken, backward taken, forward taken
        for (int i = 0; i < 9; i++)
        begin
            assert (pcTrace[i] === path[i])
                else reportMismatch($sformatf("branch step %0d at %h, expected %h",
                    i, pcTrace[i], path[i]));
        end
        finishTest("branches");
    endtask

    task automatic testZeroRegister();
        startTest();
        progWords.push_back(iType(mipsPkg::OP_LW, 0, 1, 0));
        progWords.push_back(iType(mipsPkg::OP_LW, 0, 2, 4));
        progWords.push_back(rType(1, 2, 0, mipsPkg::FUNCT_ADD));
        progWords.push_back(rType(0, 1, 3, mipsPkg::FUNCT_ADD));
        progWords.push_back(rType(2, 0, 4, mipsPkg::FUNCT_OR));
        prepare();
        runCycles(5);
        finishTest("zero register");
    endtask

    task automatic testUnknownOpcode();
        startTest();
        progWords.push_back(iType(mipsPkg::OP_LW, 0, 1, 0));
        progWords.push_back(iType(6'b001111, 1, 2, 4));
        progWords.push_back(iType(6'b111111, 0, 1, 16));
        progWords.push_back(rType(1, 1, 3, mipsPkg::FUNCT_ADD));
        prepare();
        runCycles(4);
        finishTest("unknown opcode");
    endtask

    task automatic testMidReset();
        startTest();
        // First word reads r1 and r2 before any load
        progWords.push_back(rType(1, 2, 4, mipsPkg::FUNCT_ADD));
        progWords.push_back(iType(mipsPkg::OP_LW, 0, 1, 0));
        progWords.push_back(iType(mipsPkg::OP_LW, 0, 2, 4));
        progWords.push_back(rType(1, 2, 3, mipsPkg::FUNCT_ADD));
        progWords.push_back(iType(mipsPkg::OP_SW, 0, 3, 16));
        progWords.push_back(rType(3, 1, 5, mipsPkg::FUNCT_ADD));
        prepare();
        runCycles(5);
        resetCore(RESET_CYCLES);
        releaseReset();
        runCycles(6);
        finishTest("mid-program reset");
    endtask

    initial
    begin
        reset       = 1'b1;
        instrLoad   = 1'b0;
        dataLoad    = 1'b0;
        loadAddress = '0;
        loadData    = 32'd0;
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        void'($urandom(32'h92c0));
        waitCycle();

        testLoadStore();
        testArithmetic();
        testBranches();
        testZeroRegister();
        testUnknownOpcode();
        testMidReset();

        // Concurrent property failures count as mismatches
        errorCount = errorCount + u_mipsCore.u_mipsCore_sva.failCount;

        $display("summary: %0d run, %0d with mismatches, %0d mismatches in all",
            testsRun, testsFailed, errorCount);
        if (errorCount == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: list.f
design/mipsPkg.sv
design/mainControl.sv
design/aluUnit.sv
design/registerFile.sv
design/fetchUnit.sv
design/instructionMemory.sv
design/dataMemory.sv
design/mipsCore.sv
sim/mipsCore_sva.sv
sim/mipsCore_tb.sv

// File: run.sh
#!/bin/sh
# Build and run with Verilator, pass only if the log holds the pass line
verilator --binary --timing --assert --timescale 1ns/1ns -f list.f \
    --top-module mipsCore_tb --Mdir obj_dir -o mipsCore_sim > build.log 2>&1 \
    && ./obj_dir/mipsCore_sim > sim.log 2>&1 \
    && grep -qx "test passed" sim.log \
    || { cat build.log sim.log 2>/dev/null; exit 1; }
